// File: hdl/saArithPkg.sv
`default_nettype none

package saArithPkg;

   localparam int OperandWidth = 8;
   localparam int ProductWidth = 2 * OperandWidth;
   localparam int AccWidth = 24;

   typedef logic signed [OperandWidth-1:0] operandT;
   typedef logic signed [ProductWidth-1:0] productT;
   typedef logic signed [AccWidth-1:0] accT;   // Wraps modulo 2^AccWidth

   // One operand moving through the grid, with its job tags
   typedef struct packed {
      operandT value;
      logic valid;
      logic first;   // Restart the accumulator
   } laneT;

endpackage

`default_nettype wire

// File: hdl/saCtrlPkg.sv
`default_nettype none

package saCtrlPkg;

   localparam int MaxK = 16;

   typedef logic [$clog2(MaxK + 1) - 1:0] kLenT;   // 1 to MaxK
   typedef logic [5:0] cycleCntT;

   typedef enum logic [1:0] {
      Idle,
      Feed,
      Drain
   } seqStateT;

endpackage

`default_nettype wire

// File: hdl/boothMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module boothMultiplier (
   input wire saArithPkg::operandT multiplicand,
   input wire saArithPkg::operandT multiplier,
   output saArithPkg::productT product
);

   localparam int Digits = saArithPkg::OperandWidth / 2;
   localparam int PpWidth = saArithPkg::OperandWidth + 1;   // Room for twice the multiplicand

   wire [saArithPkg::OperandWidth:0] recode;
   wire [PpWidth:0] mcandExt;
   wire [Digits-1:0] single;
   wire [Digits-1:0] double;
   wire [Digits-1:0] neg;
   wire [Digits-1:0][PpWidth-1:0] pp;   // One's complement form when neg is set

   assign recode = {multiplier, 1'b0};   // Implicit zero below bit 0
   assign mcandExt = {multiplicand[saArithPkg::OperandWidth-1], multiplicand, 1'b0};

   for (genvar j = 0; j < Digits; j++) begin : gDigit
      wire [2:0] triplet;

      // Radix-4 encoder
      assign triplet = recode[2*j +: 3];
      assign single[j] = triplet[0] ^ triplet[1];
      assign double[j] = (triplet[2] ^ triplet[1]) & ~(triplet[0] ^ triplet[1]);
      assign neg[j] = triplet[2];

      // Selector picks 1x or 2x multiplicand, inverted for negative digits
      assign pp[j] = {PpWidth{neg[j]}}
                   ^ ((mcandExt[PpWidth:1] & {PpWidth{single[j]}})
                   | (mcandExt[PpWidth-1:0] & {PpWidth{double[j]}}));
   end

   always_comb begin : sumPartials
      saArithPkg::productT total;
      saArithPkg::productT term;

      total = '0;
      for (int j = 0; j < Digits; j++) begin
         // Sign extend, then add the two's complement correction bit
         term = saArithPkg::productT'(signed'(pp[j])) + saArithPkg::productT'(neg[j]);
         total = total + (term << (2 * j));
      end
      product = total;
   end

endmodule

`default_nettype wire

// File: hdl/prefixAdder.sv
`timescale 1ns/1ps
`default_nettype none

module prefixAdder (
   input wire saArithPkg::accT addendA,
   input wire saArithPkg::accT addendB,
   output saArithPkg::accT sum
);

   localparam int Width = saArithPkg::AccWidth;
   localparam int Levels = $clog2(Width);

   wire [Width-1:0] halfSum;
   wire [Width-1:0] carry;
   wire [Levels:0][Width-1:0] gen;
   wire [Levels-1:0][Width-1:0] prop;

   assign halfSum = addendA ^ addendB;
   assign gen[0] = addendA & addendB;
   assign prop[0] = halfSum;

   // Kogge-Stone tree with the span doubling each level
   for (genvar l = 0; l < Levels; l++) begin : gLevel
      localparam int Span = 1 << l;

      for (genvar i = 0; i < Width; i++) begin : gBit
         if (i >= Span) begin : gCombine
            assign gen[l+1][i] = gen[l][i] | (prop[l][i] & gen[l][i-Span]);
         end else begin : gPassGen
            assign gen[l+1][i] = gen[l][i];
         end

         if (l < Levels - 1) begin : gNextProp
            if (i >= Span) begin : gGroup
               assign prop[l+1][i] = prop[l][i] & prop[l][i-Span];
            end else begin : gPassProp
               assign prop[l+1][i] = prop[l][i];
            end
         end
      end
   end

   assign carry = {gen[Levels][Width-2:0], 1'b0};   // Carry out dropped
   assign sum = halfSum ^ carry;

endmodule

`default_nettype wire

// File: hdl/macPe.sv
`timescale 1ns/1ps
`default_nettype none

module macPe (
   input wire CLK,
   input wire rstN,
   input wire saArithPkg::laneT west,
   input wire saArithPkg::laneT north,
   output saArithPkg::laneT east,
   output saArithPkg::laneT south,
   output saArithPkg::accT acc
);

   saArithPkg::productT product;
   saArithPkg::accT productExt;
   saArithPkg::accT runningSum;

   boothMultiplier uMul (
      .multiplicand(west.value),
      .multiplier(north.value),
      .product(product)
   );

   assign productExt = saArithPkg::accT'(product);   // Sign extended

   prefixAdder uAdd (
      .addendA(acc),
      .addendB(productExt),
      .sum(runningSum)
   );

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         east <= '0;
         south <= '0;
         acc <= '0;
      end else begin
         east <= west;
         south <= north;
         if (west.valid && north.valid) begin
            acc <= west.first ? productExt : runningSum;   // First pair restarts the sum
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/inputSkew.sv
`timescale 1ns/1ps
`default_nettype none

module inputSkew #(
   parameter int Lanes = 4
) (
   input wire CLK,
   input wire rstN,
   input wire saArithPkg::laneT [Lanes-1:0] laneIn,
   output wire saArithPkg::laneT [Lanes-1:0] laneOut
);

   for (genvar i = 0; i < Lanes; i++) begin : gLane
      if (i == 0) begin : gDirect
         assign laneOut[i] = laneIn[i];   // Lane 0 enters undelayed
      end else begin : gDelay
         saArithPkg::laneT [i-1:0] stage;

         always_ff @(posedge CLK or negedge rstN) begin
            if (!rstN) begin
               stage <= '0;
            end else begin
               stage[0] <= laneIn[i];
               for (int s = 1; s < i; s++) begin
                  stage[s] <= stage[s-1];
               end
            end
         end

         assign laneOut[i] = stage[i-1];
      end
   end

endmodule

`default_nettype wire

// File: hdl/arrayCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module arrayCtrl #(
   parameter int Rows = 4,
   parameter int Cols = 4
) (
   input wire CLK,
   input wire rstN,
   input wire start,
   input wire saCtrlPkg::kLenT kLen,
   input wire saArithPkg::operandT [Rows-1:0] aCol,
   input wire saArithPkg::operandT [Cols-1:0] bRow,
   output saArithPkg::laneT [Rows-1:0] aLanes,
   output saArithPkg::laneT [Cols-1:0] bLanes,
   output logic busy,
   output logic done
);

   // Drain count on the edge after the far corner's last accumulate
   localparam saCtrlPkg::cycleCntT DrainLast = saCtrlPkg::cycleCntT'(Rows + Cols - 2);

   saCtrlPkg::seqStateT state;
   saCtrlPkg::cycleCntT cnt;
   saCtrlPkg::cycleCntT lastFeed;
   saCtrlPkg::kLenT kLatch;
   logic accept;
   logic feeding;

   assign accept = (state == saCtrlPkg::Idle) && start;
   assign feeding = accept || (state == saCtrlPkg::Feed);
   assign busy = (state != saCtrlPkg::Idle);
   assign lastFeed = saCtrlPkg::cycleCntT'(kLatch) - saCtrlPkg::cycleCntT'(1);

   // Tag the raw operands and zero them outside a job
   always_comb begin
      for (int r = 0; r < Rows; r++) begin
         aLanes[r].value = feeding ? aCol[r] : '0;
         aLanes[r].valid = feeding;
         aLanes[r].first = accept;
      end
      for (int c = 0; c < Cols; c++) begin
         bLanes[c].value = feeding ? bRow[c] : '0;
         bLanes[c].valid = feeding;
         bLanes[c].first = accept;
      end
   end

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         state <= saCtrlPkg::Idle;
         cnt <= '0;
         kLatch <= '0;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            saCtrlPkg::Idle: begin
               if (start) begin
                  kLatch <= kLen;
                  if (kLen > saCtrlPkg::kLenT'(1)) begin
                     state <= saCtrlPkg::Feed;
                     cnt <= saCtrlPkg::cycleCntT'(1);   // First pair taken on this edge
                  end else begin
                     state <= saCtrlPkg::Drain;
                     cnt <= '0;
                  end
               end
            end
            saCtrlPkg::Feed: begin
               if (cnt == lastFeed) begin
                  state <= saCtrlPkg::Drain;
                  cnt <= '0;
               end else begin
                  cnt <= cnt + saCtrlPkg::cycleCntT'(1);
               end
            end
            saCtrlPkg::Drain: begin
               // Wavefront still crossing the grid
               if (cnt == DrainLast) begin
                  state <= saCtrlPkg::Idle;
                  done <= 1'b1;
               end else begin
                  cnt <= cnt + saCtrlPkg::cycleCntT'(1);
               end
            end
            default: state <= saCtrlPkg::Idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/systolicArray.sv
`timescale 1ns/1ps
`default_nettype none

module systolicArray #(
   parameter int Rows = 4,
   parameter int Cols = 4
) (
   input wire CLK,
   input wire rstN,
   input wire start,
   input wire saCtrlPkg::kLenT kLen,
   input wire saArithPkg::operandT [Rows-1:0] aCol,
   input wire saArithPkg::operandT [Cols-1:0] bRow,
   output wire busy,
   output wire done,
   output wire saArithPkg::accT [Rows-1:0][Cols-1:0] result
);

   wire saArithPkg::laneT [Rows-1:0] aLanes;
   wire saArithPkg::laneT [Cols-1:0] bLanes;
   wire saArithPkg::laneT [Rows-1:0] aSkewed;
   wire saArithPkg::laneT [Cols-1:0] bSkewed;
   wire saArithPkg::laneT [Rows-1:0][Cols:0] westLane;    // Column Cols leaves the grid
   wire saArithPkg::laneT [Rows:0][Cols-1:0] northLane;   // Row Rows leaves the grid

   arrayCtrl #(.Rows(Rows), .Cols(Cols)) uCtrl (
      .CLK(CLK),
      .rstN(rstN),
      .start(start),
      .kLen(kLen),
      .aCol(aCol),
      .bRow(bRow),
      .aLanes(aLanes),
      .bLanes(bLanes),
      .busy(busy),
      .done(done)
   );

   inputSkew #(.Lanes(Rows)) uSkewA (.CLK(CLK), .rstN(rstN), .laneIn(aLanes), .laneOut(aSkewed));
   inputSkew #(.Lanes(Cols)) uSkewB (.CLK(CLK), .rstN(rstN), .laneIn(bLanes), .laneOut(bSkewed));

   for (genvar r = 0; r < Rows; r++) begin : gWestEdge
      assign westLane[r][0] = aSkewed[r];
   end

   for (genvar c = 0; c < Cols; c++) begin : gNorthEdge
      assign northLane[0][c] = bSkewed[c];
   end

   // A flows east, B flows south
   for (genvar r = 0; r < Rows; r++) begin : gRow
      for (genvar c = 0; c < Cols; c++) begin : gCol
         macPe uPe (
            .CLK(CLK),
            .rstN(rstN),
            .west(westLane[r][c]),
            .north(northLane[r][c]),
            .east(westLane[r][c+1]),
            .south(northLane[r+1][c]),
            .acc(result[r][c])
         );
      end
   end

endmodule

`default_nettype wire

// File: verif/saTb.sv
`timescale 1ns/1ps
`default_nettype none

module saTb;

   localparam int Rows = 4;
   localparam int Cols = 4;
   localparam int MaxK = saCtrlPkg::MaxK;
   localparam int JobTimeout = 100;   // Cycles

   logic CLK;
   logic rstN;
   logic start;
   saCtrlPkg::kLenT kLen;
   saArithPkg::operandT [Rows-1:0] aCol;
   saArithPkg::operandT [Cols-1:0] bRow;
   wire busy;
   wire done;
   wire saArithPkg::accT [Rows-1:0][Cols-1:0] result;

   saArithPkg::operandT aMat [Rows][MaxK];
   saArithPkg::operandT bMat [MaxK][Cols];
   int errors = 0;
   int errStart = 0;
   int testsPassed = 0;
   int testsFailed = 0;

   systolicArray #(.Rows(Rows), .Cols(Cols)) dut (
      .CLK(CLK), .rstN(rstN), .start(start), .kLen(kLen),
      .aCol(aCol), .bRow(bRow),
      .busy(busy), .done(done), .result(result)
   );

   initial CLK = 1'b0;
   always #2 CLK = ~CLK;

   task automatic checkAcc(input saArithPkg::accT got, input saArithPkg::accT exp,
                           input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   // Reference dot product of row r of A and column c of B
   function automatic saArithPkg::accT modelElement(input int r, input int c, input int len);
      int sum;
      sum = 0;
      for (int k = 0; k < len; k++) begin
         sum += int'(aMat[r][k]) * int'(bMat[k][c]);
      end
      return saArithPkg::accT'(sum);   // 24-bit wrap
   endfunction

   function automatic saArithPkg::operandT pickValue(input int mode, input int i, input int j);
      case (mode)
         1: return saArithPkg::operandT'(-128);
         2: return saArithPkg::operandT'(127);
         3: return saArithPkg::operandT'(((i + j) % 2 == 1) ? 127 : -128);   // Checkerboard
         default: return saArithPkg::operandT'($urandom);
      endcase
   endfunction

   task automatic fillOperands(input int mode);
      for (int k = 0; k < MaxK; k++) begin
         for (int r = 0; r < Rows; r++) begin
            aMat[r][k] = pickValue(mode, r, k);
         end
         for (int c = 0; c < Cols; c++) begin
            bMat[k][c] = pickValue(mode, k, c + 1);   // Opposite sign pattern to A
         end
      end
   endtask

   // Pair k of the stream, or zeros for k < 0
   task automatic driveOperands(input int k);
      for (int r = 0; r < Rows; r++) begin
         aCol[r] = (k < 0) ? '0 : aMat[r][k];
      end
      for (int c = 0; c < Cols; c++) begin
         bRow[c] = (k < 0) ? '0 : bMat[k][c];
      end
   endtask

   task automatic checkResults(input int len);
      for (int r = 0; r < Rows; r++) begin
         for (int c = 0; c < Cols; c++) begin
            checkAcc(result[r][c], modelElement(r, c, len), $sformatf("result[%0d][%0d]", r, c));
         end
      end
   endtask

   // Streams one job; a start pulse after edge spuriousAt lands while busy
   task automatic runJob(input int len, input int spuriousAt);
      int edgeIdx;
      int expEdge;
      logic seenDone;
      expEdge = len + Rows + Cols - 2;
      edgeIdx = 0;
      seenDone = 1'b0;
      start = 1'b1;
      kLen = saCtrlPkg::kLenT'(len);
      driveOperands(0);
      while (!seenDone && edgeIdx < JobTimeout) begin
         @(posedge CLK);
         #1;
         start = (edgeIdx == spuriousAt);
         driveOperands((edgeIdx + 1 < len) ? edgeIdx + 1 : -1);
         checkFlag(done, edgeIdx == expEdge, $sformatf("done after edge %0d", edgeIdx));
         checkFlag(busy, edgeIdx != expEdge, $sformatf("busy after edge %0d", edgeIdx));
         seenDone = done;
         edgeIdx++;
      end
      start = 1'b0;
      if (!seenDone) begin
         $display("Timeout: done never came within %0d cycles of start", JobTimeout);
         $display("Result: FAILED");
         $finish;
      end else begin
         checkResults(len);
      end
   endtask

   task automatic endTest(input string name);
      if (errors == errStart) begin
         testsPassed++;
         $display("Test %s: ok", name);
      end else begin
         testsFailed++;
         $display("Test %s: %0d errors", name, errors - errStart);
      end
      errStart = errors;
   endtask

   initial begin
      void'($urandom(58));
      rstN = 1'b0;
      start = 1'b0;
      kLen = '0;
      aCol = '0;
      bRow = '0;
      repeat (2) @(posedge CLK);
      #1;
      rstN = 1'b1;

      checkFlag(busy, 1'b0, "busy after reset");
      checkFlag(done, 1'b0, "done after reset");
      for (int r = 0; r < Rows; r++) begin
         for (int c = 0; c < Cols; c++) begin
            checkAcc(result[r][c], '0, $sformatf("result[%0d][%0d] after reset", r, c));
         end
      end
      endTest("reset");

      for (int j = 0; j < 20; j++) begin
         fillOperands(0);
         runJob(int'($urandom_range(MaxK, 1)), -1);
      end
      endTest("randomJobs");

      fillOperands(0);
      runJob(1, -1);   // Single outer product
      runJob(MaxK, -1);
      endTest("kLenLimits");

      for (int mode = 1; mode <= 3; mode++) begin
         fillOperands(mode);
         runJob(MaxK, -1);
      end
      endTest("cornerOperands");

      fillOperands(0);
      runJob(9, -1);
      fillOperands(0);
      runJob(5, -1);   // Started on the cycle after done
      fillOperands(0);
      runJob(8, 2);
      repeat (3 * (Rows + Cols)) begin
         @(posedge CLK);
         #1;
         checkFlag(done, 1'b0, "done while idle");
         checkFlag(busy, 1'b0, "busy while idle");
      end
      checkResults(8);
      endTest("restartAndIgnoredStart");

      $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
hdl/saArithPkg.sv
hdl/saCtrlPkg.sv
hdl/boothMultiplier.sv
hdl/prefixAdder.sv
hdl/macPe.sv
hdl/inputSkew.sv
hdl/arrayCtrl.sv
hdl/systolicArray.sv
verif/saTb.sv

// File: Bender.yml
package:
  name: systolic_array

sources:
  - hdl/saArithPkg.sv
  - hdl/saCtrlPkg.sv
  - hdl/boothMultiplier.sv
  - hdl/prefixAdder.sv
  - hdl/macPe.sv
  - hdl/inputSkew.sv
  - hdl/arrayCtrl.sv
  - hdl/systolicArray.sv
  - target: test
    files:
      - verif/saTb.sv
